//--- design/loopback_pkg.sv
// shared widths and state encodings; channel count and FIFO depth are module parameters
package loopback_pkg;

    // ========================================================================
    // stream widths
    // ========================================================================
    localparam int DATA_W = 64;  // payload bits per beat
    localparam int KEEP_W = 8;   // one enable per byte
    localparam int ID_W   = 8;   // frame tag, selects channel on ingress

    localparam int CNT_W  = 16;  // statistics counters wrap at this width

    // ========================================================================
    // state encodings
    // ========================================================================
    typedef enum logic [1:0] {
        idle,   // between frames
        store,  // writing a frame
        drop    // discarding rest of frame
    } fifo_state_t;

    typedef enum logic {
        arb_idle,  // choosing next channel
        arb_busy   // forwarding one frame
    } arb_state_t;

endpackage

//--- design/stream_if.sv
// valid/ready frame stream; widths come from loopback_pkg and are not per instance
`timescale 1ns/1ps

interface stream_if;
    import loopback_pkg::*;

    logic [DATA_W-1:0] tdata;
    logic [KEEP_W-1:0] tkeep;
    logic              tlast;
    logic              tuser;   // set on last beat marks a bad frame
    logic [ID_W-1:0]   tid;
    logic              tvalid;
    logic              tready;

    modport source (
        output tdata,
        output tkeep,
        output tlast,
        output tuser,
        output tid,
        output tvalid,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tuser,
        input  tid,
        input  tvalid,
        output tready
    );

endinterface

//--- design/frame_distributor.sv
// route is taken from tid of the first beat; frames with tid >= CH_CNT are silently consumed
`timescale 1ns/1ps

module frame_distributor #(
    parameter int CH_CNT = 2
) (
    input  logic      clk_125mhz,
    input  logic      reset,
    stream_if.sink    s_frame,
    stream_if.source  m_frame [CH_CNT]
);
    import loopback_pkg::*;

    logic [ID_W-1:0]   route_reg;  // held from first beat to tlast
    logic [ID_W-1:0]   route_cur;
    logic              in_frame;
    logic [CH_CNT-1:0] ready_vec;
    logic [CH_CNT-1:0] valid_vec;
    logic              sel_ready;

    // first beat routes on its own tid, later beats on the held route
    assign route_cur = in_frame ? route_reg : s_frame.tid;

    for (genvar i = 0; i < CH_CNT; i++) begin : g_out
        assign m_frame[i].tdata  = s_frame.tdata;
        assign m_frame[i].tkeep  = s_frame.tkeep;
        assign m_frame[i].tlast  = s_frame.tlast;
        assign m_frame[i].tuser  = s_frame.tuser;
        assign m_frame[i].tid    = s_frame.tid;
        assign m_frame[i].tvalid = s_frame.tvalid && (route_cur == i);
        assign ready_vec[i]      = m_frame[i].tready;
        assign valid_vec[i]      = m_frame[i].tvalid;
    end

    always_comb begin
        sel_ready = 1'b1;  // out-of-range id is accepted and dropped
        for (int i = 0; i < CH_CNT; i++) begin
            if (route_cur == i) begin
                sel_ready = ready_vec[i];
            end
        end
    end

    assign s_frame.tready = sel_ready;

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            in_frame  <= 1'b0;
            route_reg <= '0;
        end else if (s_frame.tvalid && s_frame.tready) begin
            if (!in_frame) begin
                route_reg <= s_frame.tid;
            end
            in_frame <= !s_frame.tlast;
        end
    end

    // a discarded frame must never leak onto any channel
    a_discard_quiet: assert property (@(posedge clk_125mhz) disable iff (reset)
        (in_frame && (route_reg >= CH_CNT)) |-> (valid_vec == '0));

endmodule

//--- design/frame_fifo.sv
// DEPTH must be a power of two; frames that do not fit the free space are dropped whole
`timescale 1ns/1ps

module frame_fifo #(
    parameter int DEPTH = 64
) (
    input  logic      clk_125mhz,
    input  logic      reset,
    stream_if.sink    s_frame,
    stream_if.source  m_frame,
    output logic      good_frame,
    output logic      drop_frame
);
    import loopback_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int WORD_W = ID_W + 1 + KEEP_W + DATA_W;

    logic [WORD_W-1:0] ram [DEPTH];

    logic [ADDR_W:0]   wr_ptr;      // next word to write
    logic [ADDR_W:0]   wr_start;    // first word of the frame being written
    logic [ADDR_W:0]   commit_ptr;  // end of data visible to the reader
    logic [ADDR_W:0]   rd_ptr;
    logic [ADDR_W:0]   level;
    logic              full;
    logic              beat;
    logic              wr_en;
    logic [WORD_W-1:0] rd_word;
    fifo_state_t       state;

    // ========================================================================
    // write side
    // ========================================================================
    assign s_frame.tready = 1'b1;        // ingress never stalls
    assign beat  = s_frame.tvalid;
    assign level = wr_ptr - rd_ptr;
    assign full  = (level == (ADDR_W+1)'(DEPTH));
    assign wr_en = beat && (state != drop) && !full;

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            ram[wr_ptr[ADDR_W-1:0]] <= {s_frame.tid, s_frame.tlast,
                                        s_frame.tkeep, s_frame.tdata};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            state      <= idle;
            wr_ptr     <= '0;
            wr_start   <= '0;
            commit_ptr <= '0;
            good_frame <= 1'b0;
            drop_frame <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            drop_frame <= 1'b0;
            commit_ptr <= wr_start;      // publish one cycle after the frame closes
            if (beat) begin
                case (state)
                    idle, store: begin
                        // full also catches frames longer than DEPTH
                        if (full || (s_frame.tlast && s_frame.tuser)) begin
                            wr_ptr <= wr_start;  // rewind the partial frame
                            if (s_frame.tlast) begin
                                drop_frame <= 1'b1;
                                state      <= idle;
                            end else begin
                                state <= drop;
                            end
                        end else if (s_frame.tlast) begin
                            wr_ptr     <= wr_ptr + 1'b1;
                            wr_start   <= wr_ptr + 1'b1;
                            good_frame <= 1'b1;
                            state      <= idle;
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            state  <= store;
                        end
                    end
                    default: begin           // drop until the frame ends
                        if (s_frame.tlast) begin
                            drop_frame <= 1'b1;
                            state      <= idle;
                        end
                    end
                endcase
            end
        end
    end

    // ========================================================================
    // read side
    // ========================================================================
    assign rd_word        = ram[rd_ptr[ADDR_W-1:0]];
    assign m_frame.tvalid = (rd_ptr != commit_ptr);  // committed words only
    assign {m_frame.tid, m_frame.tlast, m_frame.tkeep, m_frame.tdata} = rd_word;
    assign m_frame.tuser  = 1'b0;                    // bad frames never leave

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (m_frame.tvalid && m_frame.tready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_level_bound: assert property (@(posedge clk_125mhz) disable iff (reset)
        level <= (ADDR_W+1)'(DEPTH));

endmodule

//--- design/egress_arbiter.sv
// whole frames are granted round robin; output tid carries the channel index, not the ingress id
`timescale 1ns/1ps

module egress_arbiter #(
    parameter int CH_CNT = 2
) (
    input  logic      clk_125mhz,
    input  logic      reset,
    stream_if.sink    s_frame [CH_CNT],
    stream_if.source  m_frame
);
    import loopback_pkg::*;

    localparam int GNT_W = (CH_CNT > 1) ? $clog2(CH_CNT) : 1;

    logic [DATA_W-1:0] data_arr [CH_CNT];
    logic [KEEP_W-1:0] keep_arr [CH_CNT];
    logic [CH_CNT-1:0] last_vec;
    logic [CH_CNT-1:0] user_vec;
    logic [CH_CNT-1:0] valid_vec;
    logic [GNT_W-1:0]  grant;
    logic [GNT_W-1:0]  next_grant;
    logic              next_valid;
    arb_state_t        state;

    for (genvar i = 0; i < CH_CNT; i++) begin : g_in
        assign data_arr[i]  = s_frame[i].tdata;
        assign keep_arr[i]  = s_frame[i].tkeep;
        assign last_vec[i]  = s_frame[i].tlast;
        assign user_vec[i]  = s_frame[i].tuser;
        assign valid_vec[i] = s_frame[i].tvalid;
        assign s_frame[i].tready = (state == arb_busy) && (grant == i) && m_frame.tready;
    end

    // search starts one past the last granted channel
    always_comb begin
        int idx;
        next_valid = 1'b0;
        next_grant = grant;
        for (int k = 1; k <= CH_CNT; k++) begin
            idx = (int'(grant) + k) % CH_CNT;
            if (!next_valid && valid_vec[idx]) begin
                next_valid = 1'b1;
                next_grant = GNT_W'(idx);
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            state <= arb_idle;
            grant <= GNT_W'(CH_CNT - 1);  // channel 0 wins first
        end else begin
            case (state)
                arb_idle: begin
                    if (next_valid) begin
                        grant <= next_grant;
                        state <= arb_busy;
                    end
                end
                default: begin
                    if (m_frame.tvalid && m_frame.tready && m_frame.tlast) begin
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

    assign m_frame.tvalid = (state == arb_busy) && valid_vec[grant];
    assign m_frame.tdata  = data_arr[grant];
    assign m_frame.tkeep  = keep_arr[grant];
    assign m_frame.tlast  = last_vec[grant];
    assign m_frame.tuser  = user_vec[grant];
    assign m_frame.tid    = ID_W'(grant);

    a_grant_held: assert property (@(posedge clk_125mhz) disable iff (reset)
        (state == arb_busy) |=> (state == arb_idle) || $stable(grant));

    // stalled beat must not change, this depends on the FIFO holding its word too
    a_stall_stable: assert property (@(posedge clk_125mhz) disable iff (reset)
        (m_frame.tvalid && !m_frame.tready) |=>
            (m_frame.tvalid && $stable(m_frame.tdata) && $stable(m_frame.tkeep)
             && $stable(m_frame.tlast) && $stable(m_frame.tid)));

endmodule

//--- design/frame_stats.sv
// counters wrap silently at CNT_W bits and are cleared only by reset
`timescale 1ns/1ps

module frame_stats #(
    parameter int CH_CNT = 2
) (
    input  logic                            clk_125mhz,
    input  logic                            reset,
    input  logic [CH_CNT-1:0]               good_frame,
    input  logic [CH_CNT-1:0]               drop_frame,
    output logic [loopback_pkg::CNT_W-1:0]  good_count [CH_CNT],
    output logic [loopback_pkg::CNT_W-1:0]  drop_count [CH_CNT]
);

    // one good and one drop counter per channel
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            for (int i = 0; i < CH_CNT; i++) begin
                good_count[i] <= '0;
                drop_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CH_CNT; i++) begin
                if (good_frame[i]) begin
                    good_count[i] <= good_count[i] + 1'b1;  // wraps
                end
                if (drop_frame[i]) begin
                    drop_count[i] <= drop_count[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/fpga_core.sv
// single clock domain, FIFO_DEPTH a power of two; egress has no tuser since bad frames are dropped
`timescale 1ns/1ps

module fpga_core #(
    parameter int CH_CNT     = 2,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                            clk_125mhz,
    input  logic                            reset,

    // ingress stream
    input  logic [loopback_pkg::DATA_W-1:0] s_tdata,
    input  logic [loopback_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                            s_tlast,
    input  logic                            s_tuser,
    input  logic [loopback_pkg::ID_W-1:0]   s_tid,
    input  logic                            s_tvalid,
    output logic                            s_tready,

    // egress stream, tid is the channel
    output logic [loopback_pkg::DATA_W-1:0] m_tdata,
    output logic [loopback_pkg::KEEP_W-1:0] m_tkeep,
    output logic                            m_tlast,
    output logic [loopback_pkg::ID_W-1:0]   m_tid,
    output logic                            m_tvalid,
    input  logic                            m_tready,

    output logic [loopback_pkg::CNT_W-1:0]  good_count [CH_CNT],
    output logic [loopback_pkg::CNT_W-1:0]  drop_count [CH_CNT]
);

    stream_if s_axis ();
    stream_if dist_if [CH_CNT] ();
    stream_if fifo_if [CH_CNT] ();
    stream_if m_axis ();

    logic [CH_CNT-1:0] good_pulse;
    logic [CH_CNT-1:0] drop_pulse;

    // ========================================================================
    // plain ports to streams
    // ========================================================================
    assign s_axis.tdata  = s_tdata;
    assign s_axis.tkeep  = s_tkeep;
    assign s_axis.tlast  = s_tlast;
    assign s_axis.tuser  = s_tuser;
    assign s_axis.tid    = s_tid;
    assign s_axis.tvalid = s_tvalid;
    assign s_tready      = s_axis.tready;

    assign m_tdata       = m_axis.tdata;
    assign m_tkeep       = m_axis.tkeep;
    assign m_tlast       = m_axis.tlast;
    assign m_tid         = m_axis.tid;
    assign m_tvalid      = m_axis.tvalid;
    assign m_axis.tready = m_tready;

    // ========================================================================
    // datapath
    // ========================================================================
    frame_distributor #(.CH_CNT(CH_CNT)) distributor_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .s_frame    (s_axis),
        .m_frame    (dist_if)
    );

    for (genvar n = 0; n < CH_CNT; n++) begin : ch_fifo
        frame_fifo #(.DEPTH(FIFO_DEPTH)) fifo_inst (
            .clk_125mhz (clk_125mhz),
            .reset      (reset),
            .s_frame    (dist_if[n]),
            .m_frame    (fifo_if[n]),
            .good_frame (good_pulse[n]),
            .drop_frame (drop_pulse[n])
        );
    end

    egress_arbiter #(.CH_CNT(CH_CNT)) arbiter_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .s_frame    (fifo_if),
        .m_frame    (m_axis)
    );

    frame_stats #(.CH_CNT(CH_CNT)) stats_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .good_frame (good_pulse),
        .drop_frame (drop_pulse),
        .good_count (good_count),
        .drop_count (drop_count)
    );

endmodule

//--- tests/tb_fpga_core.sv
// directed tests for CH_CNT=2, FIFO_DEPTH=64; each test expects empty FIFOs and m_tready high at start
`timescale 1ns/1ps

module tb_fpga_core;
    import loopback_pkg::*;

    localparam int CH_CNT  = 2;
    localparam int TIMEOUT = 2000;  // cycles without progress before giving up

    logic              clk_125mhz;
    logic              reset;
    logic [DATA_W-1:0] s_tdata;
    logic [KEEP_W-1:0] s_tkeep;
    logic              s_tlast;
    logic              s_tuser;
    logic [ID_W-1:0]   s_tid;
    logic              s_tvalid;
    logic              s_tready;
    logic [DATA_W-1:0] m_tdata;
    logic [KEEP_W-1:0] m_tkeep;
    logic              m_tlast;
    logic [ID_W-1:0]   m_tid;
    logic              m_tvalid;
    logic              m_tready;
    logic [CNT_W-1:0]  good_count [CH_CNT];
    logic [CNT_W-1:0]  drop_count [CH_CNT];

    logic [DATA_W+KEEP_W:0] exp_q0 [$];  // {last, keep, data} per beat
    logic [DATA_W+KEEP_W:0] exp_q1 [$];
    logic [CNT_W-1:0]       good_base [CH_CNT];
    logic [CNT_W-1:0]       drop_base [CH_CNT];
    string                  test_name;
    int                     errors;
    int                     checks;
    int                     err_start;
    int                     tests_run;
    int                     tests_failed;
    bit                     timed_out;

    fpga_core #(.CH_CNT(CH_CNT), .FIFO_DEPTH(64)) fpga_core_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .s_tid      (s_tid),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .m_tdata    (m_tdata),
        .m_tkeep    (m_tkeep),
        .m_tlast    (m_tlast),
        .m_tid      (m_tid),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .good_count (good_count),
        .drop_count (drop_count)
    );

    always #4 clk_125mhz = ~clk_125mhz;  // 125 MHz

    // ========================================================================
    // helpers
    // ========================================================================
    task automatic check(input string label, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, label, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("%s: gave up waiting, %s", test_name, what);
    endtask

    // starts and ends on a falling edge
    task automatic send_frame(input logic [ID_W-1:0] id, input int len, input bit bad,
                              input bit expect_out);
        logic [DATA_W+KEEP_W:0] beat;
        int                     wait_cnt;
        for (int i = 0; i < len; i++) begin
            beat[DATA_W-1:0]             = {$urandom, $urandom};
            beat[DATA_W+KEEP_W-1:DATA_W] = (i == len - 1) ? KEEP_W'($urandom_range(255, 1)) : '1;
            beat[DATA_W+KEEP_W]          = (i == len - 1);
            s_tdata  = beat[DATA_W-1:0];
            s_tkeep  = beat[DATA_W+KEEP_W-1:DATA_W];
            s_tlast  = beat[DATA_W+KEEP_W];
            s_tuser  = bad && (i == len - 1);  // error flag only on the last beat
            s_tid    = id;
            s_tvalid = 1'b1;
            #2;
            wait_cnt = 0;
            while (!s_tready && !timed_out) begin
                @(negedge clk_125mhz);
                #2;
                wait_cnt++;
                if (wait_cnt > TIMEOUT) report_timeout("ingress tready stayed low");
            end
            if (expect_out && id == 0) exp_q0.push_back(beat);
            if (expect_out && id == 1) exp_q1.push_back(beat);
            @(negedge clk_125mhz);  // beat moved on the rising edge in between
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
    endtask

    task automatic recv_frames(input int n, input bit rand_ready);
        logic [DATA_W+KEEP_W:0] exp_beat;
        int                     got;
        int                     idle;
        bit                     found;
        got  = 0;
        idle = 0;
        while (got < n && !timed_out) begin
            m_tready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            #2;
            if (m_tvalid && m_tready) begin
                idle  = 0;
                found = 1'b1;
                if (m_tid == 0 && exp_q0.size() > 0) exp_beat = exp_q0.pop_front();
                else if (m_tid == 1 && exp_q1.size() > 0) exp_beat = exp_q1.pop_front();
                else found = 1'b0;
                if (!found) begin
                    errors++;
                    $display("%s: egress beat with tid %0d was not expected", test_name, m_tid);
                end else begin
                    check("tdata", exp_beat[DATA_W-1:0], m_tdata);
                    check("tkeep", exp_beat[DATA_W+KEEP_W-1:DATA_W], m_tkeep);
                    check("tlast", exp_beat[DATA_W+KEEP_W], m_tlast);
                end
                if (m_tlast) got++;
            end else begin
                idle++;
                if (idle > TIMEOUT) report_timeout("egress frame did not arrive");
            end
            @(negedge clk_125mhz);
        end
        m_tready = 1'b1;
    endtask

    // a frame that must never leave the core
    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            #2;
            check("egress tvalid", 0, m_tvalid);
            @(negedge clk_125mhz);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = errors;
        for (int c = 0; c < CH_CNT; c++) begin
            good_base[c] = good_count[c];
            drop_base[c] = drop_count[c];
        end
    endtask

    task automatic end_test(input int g0, input int d0, input int g1, input int d1);
        check("good_count ch0", 64'(good_base[0] + CNT_W'(g0)), good_count[0]);
        check("drop_count ch0", 64'(drop_base[0] + CNT_W'(d0)), drop_count[0]);
        check("good_count ch1", 64'(good_base[1] + CNT_W'(g1)), good_count[1]);
        check("drop_count ch1", 64'(drop_base[1] + CNT_W'(d1)), drop_count[1]);
        check("leftover beats ch0", 0, exp_q0.size());
        check("leftover beats ch1", 0, exp_q1.size());
        tests_run++;
        if (errors > err_start) tests_failed++;
        $display("%s: %s", test_name, (errors > err_start) ? "FAILED" : "ok");
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_good_frames();
        begin_test("good_frames");
        m_tready = 1'b0;  // hold both frames until the receiver watches
        send_frame(0, 5, 0, 1);
        send_frame(1, 9, 0, 1);
        recv_frames(2, 0);
        end_test(1, 0, 1, 0);
    endtask

    task automatic test_bad_frame();
        begin_test("bad_frame");
        send_frame(0, 6, 1, 0);
        expect_quiet(20);
        end_test(0, 1, 0, 0);
    endtask

    task automatic test_oversize();
        begin_test("oversize");
        send_frame(0, 70, 0, 0);  // 6 beats past the 64 word FIFO
        send_frame(0, 4, 0, 1);
        recv_frames(1, 0);
        end_test(1, 1, 0, 0);
    endtask

    task automatic test_backpressure();
        begin_test("backpressure");
        m_tready = 1'b0;
        send_frame(1, 30, 0, 1);
        send_frame(1, 30, 0, 1);
        send_frame(1, 30, 0, 0);  // only 4 words left
        recv_frames(2, 0);
        expect_quiet(40);
        end_test(0, 0, 2, 1);
    endtask

    task automatic test_bad_id();
        begin_test("bad_id");
        send_frame(5, 7, 0, 0);
        expect_quiet(20);
        end_test(0, 0, 0, 0);
    endtask

    task automatic test_interleaved();
        begin_test("interleaved");
        fork
            begin
                for (int f = 0; f < 8; f++) send_frame(ID_W'(f % 2), $urandom_range(8, 1), 0, 1);
            end
            recv_frames(8, 1);
        join
        end_test(4, 0, 4, 0);
    endtask

    initial begin
        clk_125mhz   = 1'b0;
        reset        = 1'b1;
        s_tdata      = '0;
        s_tkeep      = '0;
        s_tlast      = 1'b0;
        s_tuser      = 1'b0;
        s_tid        = '0;
        s_tvalid     = 1'b0;
        m_tready     = 1'b1;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(91726));
        repeat (5) @(negedge clk_125mhz);
        reset = 1'b0;
        @(negedge clk_125mhz);
        if (!timed_out) test_good_frames();
        if (!timed_out) test_bad_frame();
        if (!timed_out) test_oversize();
        if (!timed_out) test_backpressure();
        if (!timed_out) test_bad_id();
        if (!timed_out) test_interleaved();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
design/loopback_pkg.sv
design/stream_if.sv
design/frame_distributor.sv
design/frame_fifo.sv
design/egress_arbiter.sv
design/frame_stats.sv
design/fpga_core.sv
tests/tb_fpga_core.sv

//--- run.sh
#!/bin/sh
# build and run the fpga_core testbench with Verilator, result is taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_fpga_core -o tb_fpga_core \
    && ./obj_dir/tb_fpga_core > sim.log 2>&1 \
    || echo "build or run did not complete"

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log 2>/dev/null && echo "RESULT: PASS" && exit 0 \
    || { echo "RESULT: FAIL"; exit 1; }
